/* common/capture_macros.svh */
`ifndef CAPTURE_MACROS_SVH
`define CAPTURE_MACROS_SVH

// Buffer size per channel in bytes
// Eight samples per byte, so 32 samples
`define CAP_DEPTH_BYTES 4

// Config register map
`define CAP_ADDR_SAMPLE_DIV 2'd0
`define CAP_ADDR_BAUD_DIV 2'd1
`define CAP_ADDR_TRIG_MASK 2'd2

// Register values after reset
// 100 kHz sampling, 115200 baud at 50 MHz, center button only
`define CAP_RST_SAMPLE_DIV 16'd500
`define CAP_RST_BAUD_DIV 16'd434
`define CAP_RST_TRIG_MASK 3'b100

// Frame tag of channel 0, ASCII 'A'
`define CAP_TAG_BASE 8'h41

`endif

/* common/capture_pkg.sv */
`include "capture_macros.svh"

////////////////////////////////////////////////////////////////////////////
// Shared types for the capture and dump unit
////////////////////////////////////////////////////////////////////////////

package capture_pkg;

	// Clocks per sample tick
	typedef logic [15:0] sample_div_t;

	// Clocks per serial bit
	typedef logic [15:0] baud_div_t;

	// Byte index into one channel buffer
	typedef logic [$clog2(`CAP_DEPTH_BYTES)-1:0] buf_addr_t;

	// Data byte, buffer word and serial byte
	typedef logic [7:0] cap_byte_t;

	// One flag per channel
	// bit 0 is a, bit 1 is b, bit 2 is center
	typedef logic [2:0] chan_mask_t;

	// Controller phases
	// Encoding is shown on led[1:0]
	typedef enum logic [1:0] {
		ST_WAIT      = 2'd0,
		ST_RECORD    = 2'd1,
		ST_SEND_TAG  = 2'd2,
		ST_SEND_DATA = 2'd3
	} cap_state_t;

endpackage

/* common/rec_if.sv */
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Controller to recorder link, one per channel
////////////////////////////////////////////////////////////////////////////

interface rec_if
	import capture_pkg::*;
();

	// Driven by the controller
	logic      sample_tick;
	logic      recording;
	buf_addr_t rd_addr;

	// Driven by the recorder
	cap_byte_t rd_data;
	logic      full;

	modport ctrl (
		output sample_tick, recording, rd_addr,
		input  rd_data, full
	);

	modport rec (
		input  sample_tick, recording, rd_addr,
		output rd_data, full
	);

endinterface

/* recorder/sample_recorder.sv */
`timescale 1ns/1ps

`include "capture_macros.svh"

module sample_recorder
	import capture_pkg::*;
(
	input  logic CLK50MHZ,
	input  logic RST,
	input  logic sig,
	output logic sync_level,
	rec_if.rec   rec
);

	localparam int SAMPLES = `CAP_DEPTH_BYTES * 8;
	localparam int CNT_W   = $clog2(SAMPLES) + 1;

	// Two-flop synchronizer
	logic             sync_q1;
	logic             sync_q2;

	// Byte assembler and sample counter
	cap_byte_t        asm_byte;
	cap_byte_t        next_byte;
	logic [CNT_W-1:0] sample_cnt;
	logic             store;
	buf_addr_t        wr_addr;

	// Capture memory
	cap_byte_t        mem [`CAP_DEPTH_BYTES];

	assign sync_level = sync_q2;

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			sync_q1 <= 1'b0;
			sync_q2 <= 1'b0;
		end else begin
			sync_q1 <= sig;
			sync_q2 <= sync_q1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sampling
	////////////////////////////////////////////////////////////////////////////

	// New sample enters at the top, earliest ends in bit 0
	assign next_byte = {sync_q2, asm_byte[7:1]};
	assign store     = rec.sample_tick && rec.recording && !rec.full;
	assign wr_addr   = buf_addr_t'(sample_cnt >> 3);

	always_ff @(posedge CLK50MHZ) begin
		if (store) begin
			asm_byte <= next_byte;
		end
	end

	// Every eighth sample completes a byte
	always_ff @(posedge CLK50MHZ) begin
		if (store && sample_cnt[2:0] == 3'd7) begin
			mem[wr_addr] <= next_byte;
		end
	end

	// Counter and full flag clear whenever recording is low
	always_ff @(posedge CLK50MHZ) begin
		if (RST || !rec.recording) begin
			sample_cnt <= '0;
			rec.full   <= 1'b0;
		end else if (store) begin
			sample_cnt <= sample_cnt + 1'b1;
			if (sample_cnt == CNT_W'(SAMPLES - 1)) begin
				rec.full <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port, one cycle latency
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		rec.rd_data <= mem[rec.rd_addr];
	end

endmodule

/* hdl/capture_cfg.sv */
`timescale 1ns/1ps

`include "capture_macros.svh"

module capture_cfg
	import capture_pkg::*;
(
	input  logic        CLK50MHZ,
	input  logic        RST,
	input  logic        cfg_req,
	input  logic [1:0]  cfg_addr,
	input  logic [15:0] cfg_data,
	output logic        cfg_ack,
	output sample_div_t sample_div,
	output baud_div_t   baud_div,
	output chan_mask_t  trig_mask
);

	// First cycle of a new request
	logic wr_en;

	assign wr_en = cfg_req && !cfg_ack;

	////////////////////////////////////////////////////////////////////////////
	// Four-phase acknowledge
	////////////////////////////////////////////////////////////////////////////

	// Ack follows req by one cycle in both directions
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			cfg_ack <= 1'b0;
		end else if (wr_en) begin
			cfg_ack <= 1'b1;
		end else if (!cfg_req) begin
			cfg_ack <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			sample_div <= `CAP_RST_SAMPLE_DIV;
			baud_div   <= `CAP_RST_BAUD_DIV;
			trig_mask  <= `CAP_RST_TRIG_MASK;
		end else if (wr_en) begin
			case (cfg_addr)
				`CAP_ADDR_SAMPLE_DIV: sample_div <= cfg_data;
				`CAP_ADDR_BAUD_DIV:   baud_div   <= cfg_data;
				// Only low bits carry channel enables
				`CAP_ADDR_TRIG_MASK:  trig_mask  <= cfg_data[2:0];
				// Unmapped address, acked but dropped
				default: ;
			endcase
		end
	end

endmodule

/* hdl/capture_ctrl.sv */
`timescale 1ns/1ps

`include "capture_macros.svh"

module capture_ctrl
	import capture_pkg::*;
(
	input  logic        CLK50MHZ,
	input  logic        RST,
	input  sample_div_t sample_div,
	input  chan_mask_t  trig_mask,
	input  chan_mask_t  sync_level,
	rec_if.ctrl         rec_a,
	rec_if.ctrl         rec_b,
	rec_if.ctrl         rec_c,
	output cap_byte_t   tx_data,
	output logic        tx_valid,
	input  logic        tx_ready,
	output cap_state_t  state
);

	localparam buf_addr_t LAST_BYTE = buf_addr_t'(`CAP_DEPTH_BYTES - 1);

	chan_mask_t  level_q;
	logic        trigger;
	sample_div_t div_cnt;
	logic        tick;
	logic        all_full;
	logic [1:0]  chan_sel;
	buf_addr_t   byte_idx;
	logic        rd_pend;
	cap_byte_t   rd_mux;

	// Masked rising edge, only while idle
	assign trigger  = (state == ST_WAIT) && |(sync_level & ~level_q & trig_mask);
	assign tick     = (state == ST_RECORD) && (div_cnt == sample_div);
	assign all_full = rec_a.full && rec_b.full && rec_c.full;

	// Same tick, gate and address for every channel
	assign rec_a.sample_tick = tick;
	assign rec_b.sample_tick = tick;
	assign rec_c.sample_tick = tick;
	assign rec_a.recording   = (state == ST_RECORD);
	assign rec_b.recording   = (state == ST_RECORD);
	assign rec_c.recording   = (state == ST_RECORD);
	assign rec_a.rd_addr     = byte_idx;
	assign rec_b.rd_addr     = byte_idx;
	assign rec_c.rd_addr     = byte_idx;

	always_comb begin
		case (chan_sel)
			2'd0:    rd_mux = rec_a.rd_data;
			2'd1:    rd_mux = rec_b.rd_data;
			default: rd_mux = rec_c.rd_data;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Capture and dump sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state    <= ST_WAIT;
			level_q  <= '0;
			div_cnt  <= '0;
			chan_sel <= 2'd0;
			byte_idx <= '0;
			rd_pend  <= 1'b0;
			tx_valid <= 1'b0;
		end else begin
			level_q <= sync_level;
			case (state)
				ST_WAIT: begin
					// Counter starts at 1 so the first tick is sample_div later
					if (trigger) begin
						state   <= ST_RECORD;
						div_cnt <= 16'd1;
					end
				end
				ST_RECORD: begin
					if (all_full) begin
						state    <= ST_SEND_TAG;
						chan_sel <= 2'd0;
					end else if (tick) begin
						div_cnt <= 16'd1;
					end else begin
						div_cnt <= div_cnt + 16'd1;
					end
				end
				ST_SEND_TAG: begin
					if (!tx_valid) begin
						tx_valid <= 1'b1;
					end else if (tx_ready) begin
						tx_valid <= 1'b0;
						byte_idx <= '0;
						rd_pend  <= 1'b0;
						state    <= ST_SEND_DATA;
					end
				end
				ST_SEND_DATA: begin
					if (tx_valid) begin
						// Hold the byte until the transmitter takes it
						if (tx_ready) begin
							tx_valid <= 1'b0;
							if (byte_idx == LAST_BYTE) begin
								byte_idx <= '0;
								if (chan_sel == 2'd2) begin
									state <= ST_WAIT;
								end else begin
									chan_sel <= chan_sel + 2'd1;
									state    <= ST_SEND_TAG;
								end
							end else begin
								byte_idx <= byte_idx + 1'b1;
							end
						end
					end else if (rd_pend) begin
						tx_valid <= 1'b1;
						rd_pend  <= 1'b0;
					end else begin
						// Address settles this cycle, data is out next cycle
						rd_pend <= 1'b1;
					end
				end
				default: state <= ST_WAIT;
			endcase
		end
	end

	// Byte payload, loaded when valid is about to rise
	always_ff @(posedge CLK50MHZ) begin
		if (state == ST_SEND_TAG && !tx_valid) begin
			tx_data <= `CAP_TAG_BASE + {6'd0, chan_sel};
		end else if (state == ST_SEND_DATA && !tx_valid && rd_pend) begin
			tx_data <= rd_mux;
		end
	end

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
	import capture_pkg::*;
(
	input  logic      CLK50MHZ,
	input  logic      RST,
	input  baud_div_t baud_div,
	input  cap_byte_t tx_data,
	input  logic      tx_valid,
	output logic      tx_ready,
	output logic      txd
);

	// Stop, data, start, shifted out from bit 0
	logic [9:0] shreg;
	logic       busy;
	logic [3:0] bit_cnt;
	baud_div_t  baud_cnt;
	logic       start;
	logic       bit_end;

	assign tx_ready = !busy;
	assign start    = tx_valid && !busy;
	assign bit_end  = (baud_cnt == baud_div);

	// Line idles high since shreg fills with ones
	assign txd = shreg[0];

	////////////////////////////////////////////////////////////////////////////
	// 8N1 framing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			shreg    <= '1;
			busy     <= 1'b0;
			bit_cnt  <= 4'd0;
			baud_cnt <= '0;
		end else if (start) begin
			// Start bit goes out on the next cycle
			shreg    <= {1'b1, tx_data, 1'b0};
			busy     <= 1'b1;
			bit_cnt  <= 4'd0;
			baud_cnt <= 16'd1;
		end else if (busy) begin
			if (bit_end) begin
				baud_cnt <= 16'd1;
				shreg    <= {1'b1, shreg[9:1]};
				// Tenth bit is the stop bit
				if (bit_cnt == 4'd9) begin
					busy <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else begin
				baud_cnt <= baud_cnt + 16'd1;
			end
		end
	end

endmodule

/* hdl/capture_top.sv */
`timescale 1ns/1ps

module capture_top
	import capture_pkg::*;
(
	input  logic        CLK50MHZ,
	input  logic        RST,
	input  logic        rot_a,
	input  logic        rot_b,
	input  logic        rot_center,
	input  logic        cfg_req,
	input  logic [1:0]  cfg_addr,
	input  logic [15:0] cfg_data,
	output logic        cfg_ack,
	output logic        txd,
	output logic [7:0]  led
);

	// Config outputs
	sample_div_t sample_div;
	baud_div_t   baud_div;
	chan_mask_t  trig_mask;

	// Synchronized inputs, {center, b, a}
	chan_mask_t  sync_level;

	// Controller to transmitter byte stream
	cap_byte_t   tx_data;
	logic        tx_valid;
	logic        tx_ready;
	cap_state_t  state;

	rec_if rec_a_if ();
	rec_if rec_b_if ();
	rec_if rec_c_if ();

	capture_cfg capture_cfg_inst (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.cfg_req    (cfg_req),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.cfg_ack    (cfg_ack),
		.sample_div (sample_div),
		.baud_div   (baud_div),
		.trig_mask  (trig_mask)
	);

	capture_ctrl capture_ctrl_inst (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.sample_div (sample_div),
		.trig_mask  (trig_mask),
		.sync_level (sync_level),
		.rec_a      (rec_a_if.ctrl),
		.rec_b      (rec_b_if.ctrl),
		.rec_c      (rec_c_if.ctrl),
		.tx_data    (tx_data),
		.tx_valid   (tx_valid),
		.tx_ready   (tx_ready),
		.state      (state)
	);

	// One recorder per input
	sample_recorder rec_a_inst (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.sig        (rot_a),
		.sync_level (sync_level[0]),
		.rec        (rec_a_if.rec)
	);

	sample_recorder rec_b_inst (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.sig        (rot_b),
		.sync_level (sync_level[1]),
		.rec        (rec_b_if.rec)
	);

	sample_recorder rec_c_inst (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.sig        (rot_center),
		.sync_level (sync_level[2]),
		.rec        (rec_c_if.rec)
	);

	// All three frames share one serial line
	uart_tx uart_tx_inst (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.baud_div (baud_div),
		.tx_data  (tx_data),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.txd      (txd)
	);

	// Debug view
	// mask, full flags {c, b, a}, state
	assign led = {trig_mask, rec_c_if.full, rec_b_if.full, rec_a_if.full, state};

endmodule

/* dv/capture_tb.sv */
`timescale 1ns/1ps

`include "capture_macros.svh"

module capture_tb;

	localparam int SAMPLE_DIV = 40;
	localparam int BAUD_DIV   = 16;
	localparam int N_FIXED    = 4;
	localparam int N_ROWS     = N_FIXED + 4;
	localparam int FRAME_LEN  = 15;
	localparam int QUIET      = 200;
	// Forty sample periods, one full dump and some slack per row
	localparam int CYCLE_LIMIT = N_ROWS * (SAMPLE_DIV * 40 + FRAME_LEN * 10 * BAUD_DIV + 2000);

	logic        CLK50MHZ;
	logic        RST;
	logic        rot_a;
	logic        rot_b;
	logic        rot_center;
	logic        cfg_req;
	logic [1:0]  cfg_addr;
	logic [15:0] cfg_data;
	logic        cfg_ack;
	logic        txd;
	logic [7:0]  led;

	// Stimulus table with one row per capture
	logic [2:0]  row_mask [N_ROWS];
	int          row_trig [N_ROWS];
	// Masked-off channel raised before the real trigger or -1 for none
	int          row_probe [N_ROWS];
	logic [31:0] row_pat [N_ROWS][3];

	logic [31:0] rng;
	logic [7:0]  rx_byte;
	logic [7:0]  rx_bytes [$];
	int          start_cnt = 0;
	int          cycle_cnt = 0;
	int          checks = 0;
	int          errors = 0;

	// Cycles seen on led per state code and with every full flag set
	int          state_cycles [4];
	int          full_cycles = 0;

	capture_top capture_top_inst (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.rot_a      (rot_a),
		.rot_b      (rot_b),
		.rot_center (rot_center),
		.cfg_req    (cfg_req),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.cfg_ack    (cfg_ack),
		.txd        (txd),
		.led        (led)
	);

	always #10 CLK50MHZ = ~CLK50MHZ;

	always @(posedge CLK50MHZ) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Run stopped at %0d cycles before all rows finished", cycle_cnt);
			$display("sim failed");
			$finish;
		end
	end

	always @(negedge CLK50MHZ) begin
		if (RST === 1'b0) begin
			state_cycles[led[1:0]]++;
			if (led[4:2] == 3'b111) begin
				full_cycles++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Check and stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input int exp, input int act);
		checks++;
		assert (exp == act) else begin
			$display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			$display("At %0t: %s", $time, what);
			errors++;
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLK50MHZ);
	endtask

	// Caller sits on a rising edge
	task automatic drive_pins(input logic [2:0] v);
		rot_a      <= v[0];
		rot_b      <= v[1];
		rot_center <= v[2];
	endtask

	task automatic set_row(input int r, input logic [2:0] mask, input int trig, input int probe,
		input logic [31:0] pa, input logic [31:0] pb, input logic [31:0] pc);
		row_mask[r]   = mask;
		row_trig[r]   = trig;
		row_probe[r]  = probe;
		row_pat[r][0] = pa;
		row_pat[r][1] = pb;
		row_pat[r][2] = pc;
	endtask

	task automatic build_table();
		int trig;
		set_row(0, 3'b100, 2, -1, 32'ha5c3_0f96, 32'h1234_5678, 32'hffff_0000);
		set_row(1, 3'b001, 0, -1, 32'h0000_0001, 32'h8000_0000, 32'h5555_aaaa);
		set_row(2, 3'b010, 1, 2, 32'h3c3c_9669, 32'h0f0f_f0f0, 32'h7e81_0001);
		set_row(3, 3'b011, 0, 2, 32'hffff_ffff, 32'h0000_0000, 32'h2468_ace1);
		// Random rows always enable their own trigger channel
		for (int r = N_FIXED; r < N_ROWS; r++) begin
			rng  = xorshift32(rng);
			trig = int'(rng % 32'd3);
			rng  = xorshift32(rng);
			row_mask[r]  = rng[2:0] | (3'b001 << trig);
			row_trig[r]  = trig;
			row_probe[r] = -1;
			for (int ch = 0; ch < 3; ch++) begin
				rng = xorshift32(rng);
				row_pat[r][ch] = rng;
			end
		end
	endtask

	// Tag then four data bytes per channel with samples packed LSB first
	function automatic logic [7:0] frame_byte(input int r, input int n);
		int ch;
		int idx;
		ch  = n / 5;
		idx = n % 5;
		if (idx == 0) begin
			return `CAP_TAG_BASE + 8'(ch);
		end
		return row_pat[r][ch][8 * (idx - 1) +: 8];
	endfunction

	// Four-phase write
	task automatic write_cfg(input logic [1:0] addr, input logic [15:0] data);
		@(negedge CLK50MHZ);
		check_value("cfg_ack", 0, int'(cfg_ack));
		@(posedge CLK50MHZ);
		cfg_addr <= addr;
		cfg_data <= data;
		cfg_req  <= 1'b1;
		@(negedge CLK50MHZ);
		while (cfg_ack !== 1'b1) @(negedge CLK50MHZ);
		@(posedge CLK50MHZ);
		cfg_req <= 1'b0;
		@(negedge CLK50MHZ);
		check_true(cfg_ack == 1'b1, "cfg_ack dropped while cfg_req was still high");
		while (cfg_ack !== 1'b0) @(negedge CLK50MHZ);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Serial decoder for 8N1 at BAUD_DIV clocks per bit
	////////////////////////////////////////////////////////////////////////////

	always begin
		@(negedge CLK50MHZ);
		if (RST === 1'b0 && txd === 1'b0) begin
			start_cnt++;
			// Roughly mid start bit
			repeat (BAUD_DIV / 2 - 1) @(negedge CLK50MHZ);
			check_true(txd == 1'b0, "start bit on txd shorter than half a bit");
			for (int b = 0; b < 8; b++) begin
				repeat (BAUD_DIV) @(negedge CLK50MHZ);
				rx_byte[b] = txd;
			end
			repeat (BAUD_DIV) @(negedge CLK50MHZ);
			check_true(txd == 1'b1, "no stop bit on txd after a data byte");
			rx_bytes.push_back(rx_byte);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// One capture and dump per row
	////////////////////////////////////////////////////////////////////////////

	task automatic run_row(input int r);
		int base_err;
		int base_starts;
		int base_full;
		int base_state [4];
		base_err = errors;
		write_cfg(`CAP_ADDR_TRIG_MASK, {13'd0, row_mask[r]});
		@(negedge CLK50MHZ);
		check_value("led[7:5]", int'(row_mask[r]), int'(led[7:5]));
		// Disabled input must stay silent for a whole capture time
		if (row_probe[r] >= 0) begin
			base_starts = start_cnt;
			@(posedge CLK50MHZ);
			drive_pins(3'b001 << row_probe[r]);
			wait_cycles(SAMPLE_DIV * 33);
			check_true(start_cnt == base_starts, "masked-off input started a dump");
			@(negedge CLK50MHZ);
			check_value("led[1:0]", 0, int'(led[1:0]));
			@(posedge CLK50MHZ);
			drive_pins(3'b000);
			wait_cycles(8);
		end
		rx_bytes.delete();
		base_starts = start_cnt;
		base_full   = full_cycles;
		for (int s = 1; s < 4; s++) begin
			base_state[s] = state_cycles[s];
		end
		@(posedge CLK50MHZ);
		drive_pins(3'b001 << row_trig[r]);
		// Two synchronizer flops plus edge register and then half a period
		wait_cycles(3 + SAMPLE_DIV / 2);
		for (int k = 0; k < 32; k++) begin
			if (k > 0) begin
				wait_cycles(SAMPLE_DIV);
			end
			drive_pins({row_pat[r][2][k], row_pat[r][1][k], row_pat[r][0][k]});
		end
		wait_cycles(SAMPLE_DIV / 2 + 4);
		drive_pins(3'b000);
		// Edges while sending
		while (rx_bytes.size() < 3) @(posedge CLK50MHZ);
		drive_pins(3'b111);
		wait_cycles(4);
		drive_pins(3'b000);
		while (rx_bytes.size() < FRAME_LEN) @(posedge CLK50MHZ);
		wait_cycles(QUIET);
		@(negedge CLK50MHZ);
		check_value("rx byte count", FRAME_LEN, rx_bytes.size());
		check_value("txd start bits", FRAME_LEN, start_cnt - base_starts);
		check_value("led[1:0]", 0, int'(led[1:0]));
		check_value("led[4:2]", 0, int'(led[4:2]));
		check_true(full_cycles > base_full, "led[4:2] never showed all three full flags");
		for (int s = 1; s < 4; s++) begin
			check_true(state_cycles[s] > base_state[s],
				$sformatf("led[1:0] never showed state %0d during the capture", s));
		end
		for (int n = 0; n < FRAME_LEN; n++) begin
			check_value($sformatf("rx byte %0d", n), int'(frame_byte(r, n)), int'(rx_bytes[n]));
		end
		$display("row %0d mask %b trig %0d probe %0d: %0d errors", r, row_mask[r], row_trig[r],
			row_probe[r], errors - base_err);
	endtask

	initial begin
		CLK50MHZ   = 1'b0;
		RST        = 1'b1;
		rot_a      = 1'b0;
		rot_b      = 1'b0;
		rot_center = 1'b0;
		cfg_req    = 1'b0;
		cfg_addr   = 2'd0;
		cfg_data   = 16'd0;
		rng        = 32'h1ba9;
		build_table();
		wait_cycles(8);
		RST <= 1'b0;
		// Reset state
		@(negedge CLK50MHZ);
		check_value("txd", 1, int'(txd));
		check_value("cfg_ack", 0, int'(cfg_ack));
		check_value("led[1:0]", 0, int'(led[1:0]));
		check_value("led[7:5]", int'(`CAP_RST_TRIG_MASK), int'(led[7:5]));
		// Short timing for simulation
		write_cfg(`CAP_ADDR_SAMPLE_DIV, 16'(SAMPLE_DIV));
		write_cfg(`CAP_ADDR_BAUD_DIV, 16'(BAUD_DIV));
		// Unmapped address is acked and dropped
		write_cfg(2'd3, 16'hffff);
		@(negedge CLK50MHZ);
		check_value("led[7:5]", int'(`CAP_RST_TRIG_MASK), int'(led[7:5]));
		for (int r = 0; r < N_ROWS; r++) begin
			run_row(r);
		end
		$display("rows %0d, checks %0d, errors %0d", N_ROWS, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+common
common/capture_pkg.sv
common/rec_if.sv
recorder/sample_recorder.sv
hdl/capture_cfg.sv
hdl/capture_ctrl.sv
hdl/uart_tx.sv
hdl/capture_top.sv
dv/capture_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module capture_tb -f build.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vcapture_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# Result is decided by the log alone
if grep -q "^sim passed$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
